//--- sim.f
logic/usb_proto_pkg.sv
logic/usb_crc_pkg.sv
logic/usb_pid_parser.sv
logic/usb_ep_sink.sv
logic/usb_hsk_mux.sv
logic/usb_dev_rx.sv
tb/tb_clock.sv
tb/usb_dev_rx_tb.sv

//--- Bender.yml
package:
  name: usb_dev_rx

sources:
  - logic/usb_proto_pkg.sv
  - logic/usb_crc_pkg.sv
  - logic/usb_pid_parser.sv
  - logic/usb_ep_sink.sv
  - logic/usb_hsk_mux.sv
  - logic/usb_dev_rx.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/usb_dev_rx_tb.sv

//--- tb/usb_dev_rx_tb.sv
`timescale 1ns/1ps
module usb_dev_rx_tb;
  import usb_proto_pkg::*;
  import usb_crc_pkg::*;

  localparam int NUM_EP  = 4;
  localparam int TIMEOUT = 400;

  localparam logic [2:0] EV_SOF = 3'd1;
  localparam logic [2:0] EV_ERR = 3'd2;
  localparam logic [2:0] EV_REP = 3'd3;
  localparam logic [2:0] EV_HSK = 3'd4;

  // Report value holds setup in bit 9, endpoint in 8:7 and length in 6:0
  typedef struct packed {
    logic [2:0]  kind;
    logic [15:0] val;
  } ev_t;

  logic              clock;
  logic              reset_i;
  logic              rx_valid_i;
  logic              rx_last_i;
  logic [7:0]        rx_data_i;
  logic              rx_ready_o;
  logic [6:0]        dev_addr_i;
  logic [NUM_EP-1:0] ep_enable_i;
  logic              hsk_valid_o;
  usb_pid_t          hsk_pid_o;
  logic              hsk_ready_i;
  logic              rep_valid_o;
  logic [1:0]        rep_ep_o;
  logic [6:0]        rep_len_o;
  logic              rep_setup_o;
  logic              sof_o;
  logic [10:0]       frame_o;
  logic              crc_err_o;

  ev_t               exp_q[$];
  logic [NUM_EP-1:0] model_tog;
  logic              hold_q;
  usb_pid_t          held_pid;
  int                hold_cycles;

  tb_clock u_clock (
    .clock  (clock),
    .reset_o(reset_i)
  );

  usb_dev_rx #(
    .NUM_EP(NUM_EP)
  ) u_usb_dev_rx (
    .clock      (clock),
    .reset_i    (reset_i),
    .rx_valid_i (rx_valid_i),
    .rx_last_i  (rx_last_i),
    .rx_data_i  (rx_data_i),
    .rx_ready_o (rx_ready_o),
    .dev_addr_i (dev_addr_i),
    .ep_enable_i(ep_enable_i),
    .hsk_valid_o(hsk_valid_o),
    .hsk_pid_o  (hsk_pid_o),
    .hsk_ready_i(hsk_ready_i),
    .rep_valid_o(rep_valid_o),
    .rep_ep_o   (rep_ep_o),
    .rep_len_o  (rep_len_o),
    .rep_setup_o(rep_setup_o),
    .sof_o      (sof_o),
    .frame_o    (frame_o),
    .crc_err_o  (crc_err_o)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  // Expected outcome of one token plus data packet
  function automatic void model_response(
    input  usb_token_t        tok,
    input  usb_pid_t          tok_pid,
    input  usb_pid_t          data_pid,
    input  int                len,
    input  logic              crc_good,
    input  logic [NUM_EP-1:0] enables,
    input  logic [6:0]        addr,
    input  logic [NUM_EP-1:0] tog_in,
    output logic [NUM_EP-1:0] tog_out,
    output logic              hsk_exp,
    output usb_pid_t          hsk_pid,
    output logic              rep_exp,
    output logic [15:0]       rep_val,
    output logic              err_exp
  );
    int   ep;
    logic want1;
    logic matched;
    tog_out = tog_in;
    hsk_exp = 1'b0;
    hsk_pid = PID_NAK;
    rep_exp = 1'b0;
    rep_val = '0;
    err_exp = 1'b0;
    ep = int'(tok.addressed.endp);
    if (((tok_pid != PID_OUT) && (tok_pid != PID_SETUP)) ||
        (tok.addressed.addr != addr) || (ep >= NUM_EP)) begin
      return;
    end
    if (!crc_good) begin
      err_exp = 1'b1;
      return;
    end
    // SETUP restarts the sequence at DATA0
    want1       = (tok_pid == PID_SETUP) ? 1'b0 : tog_in[ep];
    matched     = ((data_pid == PID_DATA1) == want1);
    tog_out[ep] = matched ? !want1 : want1;
    hsk_exp     = 1'b1;
    hsk_pid     = enables[ep] ? PID_ACK : PID_NAK;
    rep_exp     = matched && enables[ep];
    rep_val     = {6'd0, (tok_pid == PID_SETUP), 2'(ep), 7'(len)};
  endfunction

  function automatic usb_token_t add_crc5(input usb_token_t t);
    usb_token_t s;
    s = t;
    for (int c = 0; c < 32; c++) begin
      s.sof.crc5 = 5'(c);
      if (crc5_step(crc5_step(CRC5_INIT, s[7:0]), s[15:8]) == CRC5_RESIDUE) begin
        return s;
      end
    end
    return s;
  endfunction

  task automatic expect_event(input logic [2:0] kind, input logic [15:0] val);
    exp_q.push_back(ev_t'({kind, val}));
  endtask

  task automatic match_event(input logic [2:0] kind, input logic [15:0] val,
                             input string name);
    ev_t e;
    if (exp_q.size() == 0) begin
      abort_run($sformatf("%s fired at %0t when no output was expected", name, $time));
    end else begin
      e = exp_q.pop_front();
      if (e.kind != kind) begin
        abort_run($sformatf("%s fired at %0t while another output was due first",
                            name, $time));
      end else if (kind == EV_REP) begin
        check_value("rep_len_o", val[6:0], e.val[6:0]);
        check_value("rep_ep_o", val[8:7], e.val[8:7]);
        check_value("rep_setup_o", val[9], e.val[9]);
      end else begin
        check_value(name, val, e.val);
      end
    end
  endtask

  // Holds the byte until a rising edge finds rx_ready_o high
  task automatic drive_byte(input logic [7:0] data, input logic last);
    int   n;
    logic taken;
    n = 0;
    taken = 1'b0;
    rx_valid_i = 1'b1;
    rx_data_i  = data;
    rx_last_i  = last;
    while (!taken) begin
      if (n == TIMEOUT) begin
        abort_run("A byte waited too long for rx_ready_o");
      end
      @(negedge clock);
      taken = rx_ready_o;
      @(posedge clock);
      #2;
      n++;
    end
    rx_valid_i = 1'b0;
    rx_last_i  = 1'b0;
  endtask

  task automatic emit_token(input usb_pid_t pid, input usb_token_t tok);
    drive_byte({~pid, pid}, 1'b0);
    drive_byte(tok[7:0], 1'b0);
    drive_byte(tok[15:8], 1'b1);
  endtask

  task automatic transmit_data(input usb_pid_t pid, input int len, input logic corrupt);
    logic [15:0] crc;
    logic [15:0] tail;
    logic [7:0]  b;
    crc = CRC16_INIT;
    drive_byte({~pid, pid}, 1'b0);
    for (int i = 0; i < len; i++) begin
      b   = 8'($urandom);
      crc = crc16_step(crc, b);
      drive_byte(b, 1'b0);
    end
    tail = ~crc;
    if (crc16_step(crc16_step(crc, tail[7:0]), tail[15:8]) != CRC16_RESIDUE) begin
      abort_run("Packet builder formed a CRC16 that misses the residue");
    end
    if (corrupt) begin
      tail[5] = !tail[5];
    end
    drive_byte(tail[7:0], 1'b0);
    drive_byte(tail[15:8], 1'b1);
  endtask

  task automatic sof_frame(input logic [10:0] frame, input logic corrupt);
    usb_token_t tok;
    tok = '0;
    tok.sof.frame = frame;
    tok = add_crc5(tok);
    if (corrupt) begin
      tok.sof.crc5[0] = !tok.sof.crc5[0];
      expect_event(EV_ERR, 16'd0);
    end else begin
      expect_event(EV_SOF, 16'(frame));
    end
    emit_token(PID_SOF, tok);
  endtask

  task automatic out_transfer(input usb_pid_t tok_pid, input logic [6:0] addr,
                              input logic [3:0] endp, input usb_pid_t data_pid,
                              input int len, input logic corrupt);
    usb_token_t        tok;
    logic [NUM_EP-1:0] tog_next;
    logic              hsk_exp;
    usb_pid_t          hsk_pid;
    logic              rep_exp;
    logic [15:0]       rep_val;
    logic              err_exp;
    tok = '0;
    tok.addressed.addr = addr;
    tok.addressed.endp = endp;
    tok = add_crc5(tok);
    model_response(tok, tok_pid, data_pid, len, !corrupt, ep_enable_i, dev_addr_i,
                   model_tog, tog_next, hsk_exp, hsk_pid, rep_exp, rep_val, err_exp);
    model_tog = tog_next;
    if (err_exp) begin
      expect_event(EV_ERR, 16'd0);
    end
    // Report pulses on the same cycle the handshake first shows
    if (rep_exp) begin
      expect_event(EV_REP, rep_val);
    end
    if (hsk_exp) begin
      expect_event(EV_HSK, 16'(hsk_pid));
    end
    emit_token(tok_pid, tok);
    transmit_data(data_pid, len, corrupt);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n == TIMEOUT) begin
        abort_run("An expected DUT output never appeared");
      end
      @(posedge clock);
      #2;
      n++;
    end
    // Quiet stretch so stray outputs get caught
    repeat (6) @(posedge clock);
    #2;
  endtask

  task automatic wait_hsk();
    int n;
    n = 0;
    while (!hsk_valid_o) begin
      if (n == TIMEOUT) begin
        abort_run("hsk_valid_o never rose during the back-pressure test");
      end
      @(posedge clock);
      #2;
      n++;
    end
  endtask

  // Compare process, samples between edges
  initial begin
    hold_q = 1'b0;
    forever begin
      @(negedge clock);
      if (reset_i) begin
        hold_q = 1'b0;
      end else begin
        check_value("rx_ready_o", rx_ready_o, !hsk_valid_o);
        if (hold_q) begin
          check_value("hsk_valid_o", hsk_valid_o, 1'b1);
          check_value("hsk_pid_o", hsk_pid_o, held_pid);
        end
        if (sof_o) begin
          match_event(EV_SOF, 16'(frame_o), "frame_o");
        end
        if (crc_err_o) begin
          match_event(EV_ERR, 16'd0, "crc_err_o");
        end
        if (rep_valid_o) begin
          match_event(EV_REP, {6'd0, rep_setup_o, rep_ep_o, rep_len_o}, "rep_valid_o");
        end
        if (hsk_valid_o && hsk_ready_i) begin
          match_event(EV_HSK, 16'(hsk_pid_o), "hsk_pid_o");
        end
        hold_q   = hsk_valid_o && !hsk_ready_i;
        held_pid = hsk_pid_o;
      end
    end
  end

  initial begin
    int n;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(48191));
    rx_valid_i  = 1'b0;
    rx_last_i   = 1'b0;
    rx_data_i   = 8'h00;
    dev_addr_i  = 7'h2a;
    ep_enable_i = 4'b0111;
    hsk_ready_i = 1'b1;
    model_tog   = '0;
    n = 0;
    @(posedge clock);
    #2;
    while (reset_i) begin
      if (n == TIMEOUT) begin
        abort_run("Reset was never released");
      end
      @(posedge clock);
      #2;
      n++;
    end
    check_value("rx_ready_o", rx_ready_o, 1'b1);
    check_value("hsk_valid_o", hsk_valid_o, 1'b0);
    check_value("rep_valid_o", rep_valid_o, 1'b0);
    check_value("sof_o", sof_o, 1'b0);
    check_value("crc_err_o", crc_err_o, 1'b0);

    // Frame numbers, good and with a broken CRC5
    sof_frame(11'($urandom), 1'b0);
    sof_frame(11'($urandom), 1'b1);
    wait_idle();

    // Control setup then an OUT on endpoint 1
    out_transfer(PID_SETUP, dev_addr_i, 4'd1, PID_DATA0, 8, 1'b0);
    out_transfer(PID_OUT, dev_addr_i, 4'd1, PID_DATA1, $urandom_range(1, 32), 1'b0);
    wait_idle();

    // Duplicate toggle, foreign address, endpoint out of range
    out_transfer(PID_OUT, dev_addr_i, 4'd1, PID_DATA1, $urandom_range(1, 32), 1'b0);
    out_transfer(PID_OUT, dev_addr_i ^ 7'h01, 4'd0, PID_DATA0, $urandom_range(1, 32), 1'b0);
    out_transfer(PID_OUT, dev_addr_i, 4'd5, PID_DATA0, $urandom_range(1, 32), 1'b0);
    wait_idle();

    // Broken CRC16, then endpoint 3 which is disabled
    out_transfer(PID_OUT, dev_addr_i, 4'd2, PID_DATA0, $urandom_range(1, 32), 1'b1);
    out_transfer(PID_OUT, dev_addr_i, 4'd3, PID_DATA0, $urandom_range(1, 32), 1'b0);
    for (int i = 0; i < 12; i++) begin
      out_transfer(PID_OUT, dev_addr_i, 4'($urandom_range(0, 3)),
                   ($urandom_range(0, 1) != 0) ? PID_DATA1 : PID_DATA0,
                   $urandom_range(1, 32), ($urandom_range(0, 5) == 0));
    end
    wait_idle();

    // Transmit side stalls while the next packet is already arriving
    hold_cycles = $urandom_range(3, 12);
    hsk_ready_i = 1'b0;
    fork
      begin
        out_transfer(PID_OUT, dev_addr_i, 4'd0, model_tog[0] ? PID_DATA1 : PID_DATA0,
                     $urandom_range(1, 32), 1'b0);
        out_transfer(PID_OUT, dev_addr_i, 4'd2,
                     ($urandom_range(0, 1) != 0) ? PID_DATA1 : PID_DATA0,
                     $urandom_range(1, 32), 1'b0);
      end
      begin
        wait_hsk();
        repeat (hold_cycles) @(posedge clock);
        #2;
        hsk_ready_i = 1'b1;
      end
    join
    wait_idle();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps
module tb_clock #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clock,
  output logic reset_o
);

  initial begin
    clock = 1'b0;
    forever begin
      #HALF_PERIOD;
      clock = ~clock;
    end
  end

  // Reset covers the first rising edges, released right at the last one
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset_o <= 1'b0;
  end

endmodule

//--- logic/usb_dev_rx.sv
`timescale 1ns/1ps
module usb_dev_rx #(
  parameter int NUM_EP = 4,
  localparam int EP_W = (NUM_EP > 1) ? $clog2(NUM_EP) : 1
) (
  input  logic                    clock,
  input  logic                    reset_i,
  input  logic                    rx_valid_i,
  input  logic                    rx_last_i,
  input  logic [7:0]              rx_data_i,
  output logic                    rx_ready_o,
  input  logic [6:0]              dev_addr_i,
  input  logic [NUM_EP-1:0]       ep_enable_i,
  output logic                    hsk_valid_o,
  output usb_proto_pkg::usb_pid_t hsk_pid_o,
  input  logic                    hsk_ready_i,
  output logic                    rep_valid_o,
  output logic [EP_W-1:0]         rep_ep_o,
  output logic [6:0]              rep_len_o,
  output logic                    rep_setup_o,
  output logic                    sof_o,
  output logic [10:0]             frame_o,
  output logic                    crc_err_o
);
  import usb_proto_pkg::*;

  logic                byte_valid;
  logic [7:0]          byte_data;
  logic                byte_last;
  logic                pkt_start;
  usb_pid_t            pkt_pid;
  logic                setup_seen;
  logic [NUM_EP-1:0]   ep_sel;
  logic                tok_crc_err;
  logic                hsk_busy;
  logic [NUM_EP-1:0]   ep_done;
  logic [NUM_EP*2-1:0] ep_status;
  logic [NUM_EP*7-1:0] ep_len;
  logic [NUM_EP-1:0]   ep_setup;

  usb_pid_parser #(
    .NUM_EP(NUM_EP)
  ) u_parser (
    .clock        (clock),
    .reset_i      (reset_i),
    .rx_valid_i   (rx_valid_i),
    .rx_last_i    (rx_last_i),
    .rx_data_i    (rx_data_i),
    .rx_ready_o   (rx_ready_o),
    .dev_addr_i   (dev_addr_i),
    .hsk_busy_i   (hsk_busy),
    .sof_o        (sof_o),
    .frame_o      (frame_o),
    .tok_crc_err_o(tok_crc_err),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data),
    .byte_last_o  (byte_last),
    .pkt_start_o  (pkt_start),
    .pkt_pid_o    (pkt_pid),
    .setup_seen_o (setup_seen),
    .ep_sel_o     (ep_sel)
  );

  for (genvar i = 0; i < NUM_EP; i++) begin : g_ep
    usb_ep_sink u_sink (
      .clock       (clock),
      .reset_i     (reset_i),
      .sel_i       (ep_sel[i]),
      .byte_valid_i(byte_valid),
      .byte_data_i (byte_data),
      .byte_last_i (byte_last),
      .pkt_start_i (pkt_start),
      .pkt_pid_i   (pkt_pid),
      .setup_i     (setup_seen),
      .done_o      (ep_done[i]),
      .status_o    (ep_status[i*2 +: 2]),
      .len_o       (ep_len[i*7 +: 7]),
      .is_setup_o  (ep_setup[i])
    );
  end

  usb_hsk_mux #(
    .NUM_EP(NUM_EP)
  ) u_hsk_mux (
    .clock        (clock),
    .reset_i      (reset_i),
    .done_i       (ep_done),
    .status_i     (ep_status),
    .len_i        (ep_len),
    .setup_i      (ep_setup),
    .ep_enable_i  (ep_enable_i),
    .hsk_ready_i  (hsk_ready_i),
    .tok_crc_err_i(tok_crc_err),
    .hsk_valid_o  (hsk_valid_o),
    .hsk_pid_o    (hsk_pid_o),
    .hsk_busy_o   (hsk_busy),
    .rep_valid_o  (rep_valid_o),
    .rep_ep_o     (rep_ep_o),
    .rep_len_o    (rep_len_o),
    .rep_setup_o  (rep_setup_o),
    .crc_err_o    (crc_err_o)
  );

endmodule

//--- logic/usb_hsk_mux.sv
`timescale 1ns/1ps
module usb_hsk_mux #(
  parameter int NUM_EP = 4,
  localparam int EP_W = (NUM_EP > 1) ? $clog2(NUM_EP) : 1
) (
  input  logic                    clock,
  input  logic                    reset_i,
  input  logic [NUM_EP-1:0]       done_i,
  input  logic [NUM_EP*2-1:0]     status_i,
  input  logic [NUM_EP*7-1:0]     len_i,
  input  logic [NUM_EP-1:0]       setup_i,
  input  logic [NUM_EP-1:0]       ep_enable_i,
  input  logic                    hsk_ready_i,
  input  logic                    tok_crc_err_i,
  output logic                    hsk_valid_o,
  output usb_proto_pkg::usb_pid_t hsk_pid_o,
  output logic                    hsk_busy_o,
  output logic                    rep_valid_o,
  output logic [EP_W-1:0]         rep_ep_o,
  output logic [6:0]              rep_len_o,
  output logic                    rep_setup_o,
  output logic                    crc_err_o
);
  import usb_proto_pkg::*;

  logic            any_done;
  logic [EP_W-1:0] idx;
  logic [1:0]      st;
  logic            en_sel;
  logic            hsk_valid_q;
  usb_pid_t        hsk_pid_q;
  logic            rep_valid_q;
  logic            crc_bad_q;

  assign any_done = |done_i;

  always_comb begin
    idx = '0;
    for (int i = 0; i < NUM_EP; i++) begin
      if (done_i[i]) begin
        idx = EP_W'(i);
      end
    end
  end

  assign st     = status_i[idx*2 +: 2];
  assign en_sel = ep_enable_i[idx];

  assign hsk_valid_o = hsk_valid_q;
  assign hsk_pid_o   = hsk_pid_q;
  assign hsk_busy_o  = hsk_valid_q;
  assign rep_valid_o = rep_valid_q;
  // Token errors come from the parser a cycle earlier than data errors
  assign crc_err_o   = tok_crc_err_i || crc_bad_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      hsk_valid_q <= 1'b0;
      rep_valid_q <= 1'b0;
      crc_bad_q   <= 1'b0;
    end else begin
      rep_valid_q <= any_done && (st == EP_ST_OK) && en_sel;
      crc_bad_q   <= any_done && (st == EP_ST_CRC_BAD);
      if (hsk_valid_q && hsk_ready_i) begin
        hsk_valid_q <= 1'b0;
      end
      if (any_done && (st != EP_ST_CRC_BAD)) begin
        hsk_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (any_done) begin
      hsk_pid_q   <= en_sel ? PID_ACK : PID_NAK;
      rep_ep_o    <= idx;
      rep_len_o   <= len_i[idx*7 +: 7];
      rep_setup_o <= setup_i[idx];
    end
  end

  a_done_onehot: assert property (@(posedge clock) disable iff (reset_i)
    $onehot0(done_i));

  a_hsk_hold: assert property (@(posedge clock) disable iff (reset_i)
    hsk_valid_o && !hsk_ready_i |=> hsk_valid_o && $stable(hsk_pid_o));

endmodule

//--- logic/usb_ep_sink.sv
`timescale 1ns/1ps
module usb_ep_sink (
  input  logic                    clock,
  input  logic                    reset_i,
  input  logic                    sel_i,
  input  logic                    byte_valid_i,
  input  logic [7:0]              byte_data_i,
  input  logic                    byte_last_i,
  input  logic                    pkt_start_i,
  input  usb_proto_pkg::usb_pid_t pkt_pid_i,
  input  logic                    setup_i,
  output logic                    done_o,
  output logic [1:0]              status_o,
  output logic [6:0]              len_o,
  output logic                    is_setup_o
);
  import usb_proto_pkg::*;
  import usb_crc_pkg::*;

  logic        active_q;
  logic [15:0] crc_q;
  logic [6:0]  cnt_q;
  usb_pid_t    pid_q;
  logic        setup_q;
  // Expected toggle, low means DATA0
  logic        toggle_q;
  logic        done_q;
  logic [1:0]  status_q;
  logic [6:0]  len_q;
  logic        is_setup_q;

  logic        take;
  logic [15:0] crc_next;
  logic [6:0]  cnt_next;
  logic        crc_ok;
  logic        exp_tog;
  logic        pid_tog;

  assign take     = sel_i && active_q && byte_valid_i;
  assign crc_next = crc16_step(crc_q, byte_data_i);
  assign cnt_next = (cnt_q == 7'h7f) ? cnt_q : cnt_q + 7'd1;
  assign crc_ok   = (crc_next == CRC16_RESIDUE) && (cnt_next >= 7'd2);

  // A SETUP stage always starts on DATA0
  assign exp_tog = setup_q ? 1'b0 : toggle_q;
  assign pid_tog = (pid_q == PID_DATA1);

  assign done_o     = done_q;
  assign status_o   = status_q;
  assign len_o      = len_q;
  assign is_setup_o = is_setup_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      active_q <= 1'b0;
      toggle_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (pkt_start_i && sel_i && (pid_class(pkt_pid_i) == CLS_DATA)) begin
        active_q <= 1'b1;
      end else if (take && byte_last_i) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
        if (crc_ok) begin
          toggle_q <= (pid_tog == exp_tog) ? !exp_tog : exp_tog;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pkt_start_i && sel_i) begin
      crc_q   <= CRC16_INIT;
      cnt_q   <= 7'd0;
      pid_q   <= pkt_pid_i;
      setup_q <= setup_i;
    end else if (take) begin
      crc_q <= crc_next;
      cnt_q <= cnt_next;
      if (byte_last_i) begin
        // The two CRC bytes are not payload
        len_q      <= (cnt_next >= 7'd2) ? cnt_next - 7'd2 : 7'd0;
        is_setup_q <= setup_q;
        if (!crc_ok) begin
          status_q <= EP_ST_CRC_BAD;
        end else if (pid_tog != exp_tog) begin
          status_q <= EP_ST_DUP;
        end else begin
          status_q <= EP_ST_OK;
        end
      end
    end
  end

  // A started packet keeps this endpoint selected up to its last byte
  a_sel_held: assert property (@(posedge clock) disable iff (reset_i)
    active_q |-> sel_i);

endmodule

//--- logic/usb_pid_parser.sv
`timescale 1ns/1ps
module usb_pid_parser #(
  parameter int NUM_EP = 4
) (
  input  logic                    clock,
  input  logic                    reset_i,
  input  logic                    rx_valid_i,
  input  logic                    rx_last_i,
  input  logic [7:0]              rx_data_i,
  output logic                    rx_ready_o,
  input  logic [6:0]              dev_addr_i,
  input  logic                    hsk_busy_i,
  output logic                    sof_o,
  output logic [10:0]             frame_o,
  output logic                    tok_crc_err_o,
  output logic                    byte_valid_o,
  output logic [7:0]              byte_data_o,
  output logic                    byte_last_o,
  output logic                    pkt_start_o,
  output usb_proto_pkg::usb_pid_t pkt_pid_o,
  output logic                    setup_seen_o,
  output logic [NUM_EP-1:0]       ep_sel_o
);
  import usb_proto_pkg::*;
  import usb_crc_pkg::*;

  localparam int EP_W = (NUM_EP > 1) ? $clog2(NUM_EP) : 1;

  logic            first_q;
  logic [1:0]      cnt_q;
  logic            drop_q;
  usb_pkt_class_t  cls_q;
  usb_pid_t        pid_q;
  logic [7:0]      tok_lo_q;
  logic [4:0]      crc5_q;
  logic            data_q;
  logic            armed_q;
  logic [EP_W-1:0] tok_ep_q;
  logic            tok_setup_q;
  logic            sof_q;
  logic [10:0]     frame_q;
  logic            crc_err_q;

  logic            rx_fire;
  logic            pid_ok;
  usb_pkt_class_t  pid_cls;
  logic [4:0]      crc5_next;
  usb_token_t      tok_w;
  logic            tok_end;
  logic            tok_crc_ok;
  logic            tok_for_us;

  // No new byte while a handshake waits for the transmit side
  assign rx_ready_o = !hsk_busy_i;
  assign rx_fire    = rx_valid_i && rx_ready_o;

  assign pid_ok    = (rx_data_i[3:0] == ~rx_data_i[7:4]);
  assign pid_cls   = pid_class(rx_data_i[3:0]);
  assign crc5_next = crc5_step(crc5_q, rx_data_i);

  // Same 16 bits read as an addressed token or as a frame number
  assign tok_w      = usb_token_t'({rx_data_i, tok_lo_q});
  assign tok_crc_ok = (crc5_next == CRC5_RESIDUE);
  assign tok_for_us = (tok_w.addressed.addr == dev_addr_i) &&
                      (int'(tok_w.addressed.endp) < NUM_EP);

  // Second payload byte of a three-byte token or SOF
  assign tok_end = rx_fire && !first_q && !drop_q && rx_last_i && (cnt_q == 2'd1) &&
                   ((cls_q == CLS_TOKEN) || (cls_q == CLS_SOF));

  // A data PID is only routed when a token for this device came first
  assign pkt_start_o  = rx_fire && first_q && pid_ok && !rx_last_i &&
                        (pid_cls == CLS_DATA) && armed_q;
  assign pkt_pid_o    = usb_pid_t'(rx_data_i[3:0]);
  assign byte_valid_o = rx_fire && data_q;
  assign byte_data_o  = rx_data_i;
  assign byte_last_o  = rx_last_i;
  assign setup_seen_o = tok_setup_q;

  assign sof_o         = sof_q;
  assign frame_o       = frame_q;
  assign tok_crc_err_o = crc_err_q;

  always_comb begin
    ep_sel_o = '0;
    if (armed_q) begin
      ep_sel_o[tok_ep_q] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      first_q     <= 1'b1;
      cnt_q       <= 2'd0;
      drop_q      <= 1'b0;
      cls_q       <= CLS_INVALID;
      data_q      <= 1'b0;
      armed_q     <= 1'b0;
      tok_setup_q <= 1'b0;
      sof_q       <= 1'b0;
      crc_err_q   <= 1'b0;
    end else begin
      sof_q     <= 1'b0;
      crc_err_q <= 1'b0;
      if (rx_fire) begin
        first_q <= rx_last_i;
        if (first_q) begin
          cnt_q  <= 2'd0;
          drop_q <= !pid_ok;
          cls_q  <= pid_cls;
          data_q <= pkt_start_o;
          // A data PID with nothing behind it still uses up the token
          if (pid_ok && (pid_cls == CLS_DATA) && rx_last_i) begin
            armed_q <= 1'b0;
          end
        end else begin
          if (cnt_q != 2'd3) begin
            cnt_q <= cnt_q + 2'd1;
          end
          if (data_q && rx_last_i) begin
            data_q  <= 1'b0;
            armed_q <= 1'b0;
          end
        end
        if (tok_end) begin
          if (cls_q == CLS_SOF) begin
            sof_q     <= tok_crc_ok;
            crc_err_q <= !tok_crc_ok;
          end else begin
            crc_err_q   <= !tok_crc_ok;
            armed_q     <= tok_crc_ok && tok_for_us &&
                           ((pid_q == PID_OUT) || (pid_q == PID_SETUP));
            tok_setup_q <= (pid_q == PID_SETUP);
          end
        end
      end
    end
  end

  // Payload registers
  always_ff @(posedge clock) begin
    if (rx_fire) begin
      if (first_q) begin
        pid_q  <= usb_pid_t'(rx_data_i[3:0]);
        crc5_q <= CRC5_INIT;
      end else begin
        crc5_q <= crc5_next;
        if (cnt_q == 2'd0) begin
          tok_lo_q <= rx_data_i;
        end
      end
      if (tok_end && tok_crc_ok) begin
        frame_q  <= tok_w.sof.frame;
        tok_ep_q <= tok_w.addressed.endp[EP_W-1:0];
      end
    end
  end

  // Every routed data byte lands in exactly one endpoint
  a_byte_routed: assert property (@(posedge clock) disable iff (reset_i)
    byte_valid_o |-> $onehot(ep_sel_o));

endmodule

//--- logic/usb_crc_pkg.sv
package usb_crc_pkg;

  // Both CRCs run LSB first, so the registers shift right with reflected polynomials
  localparam logic [4:0]  CRC5_INIT   = 5'h1f;
  localparam logic [4:0]  CRC5_POLY   = 5'b10100;
  localparam logic [15:0] CRC16_INIT  = 16'hffff;
  localparam logic [15:0] CRC16_POLY  = 16'ha001;

  // Register contents after a field and its inverted CRC pass through
  localparam logic [4:0]  CRC5_RESIDUE  = 5'b00110;
  localparam logic [15:0] CRC16_RESIDUE = 16'hb001;

  function automatic logic [4:0] crc5_step(
    input logic [4:0] crc,
    input logic [7:0] data
  );
    logic [4:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ CRC5_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_step(
    input logic [15:0] crc,
    input logic [7:0]  data
  );
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ CRC16_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

//--- logic/usb_proto_pkg.sv
package usb_proto_pkg;

  // Low nibble of the PID byte, the high nibble carries its complement
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010
  } usb_pid_t;

  typedef enum logic [2:0] {
    CLS_TOKEN,
    CLS_SOF,
    CLS_DATA,
    CLS_HSK,
    CLS_INVALID
  } usb_pkt_class_t;

  // Endpoint completion status
  localparam logic [1:0] EP_ST_OK      = 2'd0;
  localparam logic [1:0] EP_ST_CRC_BAD = 2'd1;
  localparam logic [1:0] EP_ST_DUP     = 2'd2;

  // Second token byte in the upper half, first byte in the lower half
  typedef struct packed {
    logic [4:0] crc5;
    logic [3:0] endp;
    logic [6:0] addr;
  } usb_tok_addr_t;

  typedef struct packed {
    logic [4:0]  crc5;
    logic [10:0] frame;
  } usb_tok_sof_t;

  typedef union packed {
    usb_tok_addr_t addressed;
    usb_tok_sof_t  sof;
  } usb_token_t;

  function automatic usb_pkt_class_t pid_class(input logic [3:0] pid);
    case (pid)
      PID_OUT, PID_IN, PID_SETUP: return CLS_TOKEN;
      PID_SOF:                    return CLS_SOF;
      PID_DATA0, PID_DATA1:       return CLS_DATA;
      PID_ACK, PID_NAK:           return CLS_HSK;
      default:                    return CLS_INVALID;
    endcase
  endfunction

endpackage
